/* Makefile */
VERILATOR  ?= verilator
TOP        := sparce_tb
RTL_TOP    := sparce_top
FILELIST   := filelist.f
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := NO ERRORS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) +verilator+error+limit+100 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* filelist.f */
verilog/sparce_pkg.sv
verilog/sasa_table.sv
verilog/zero_reg_tracker.sv
verilog/skip_decider.sv
verilog/sasa_cfg_port.sv
verilog/sparce_top.sv
tb/sparce_chk.sv
tb/sparce_tb.sv

/* tb/sparce_chk.sv */
/*
 * Protocol checks bound into the front end top level.
 * Covers the four-phase config handshake and the skip enable gating.
 */
module sparce_chk (
  input logic CLK,
  input logic nRST,
  input logic cfg_req,
  input logic cfg_ack,
  input logic skip_valid,
  input logic enable
);

  // count of failed assertions
  int unsigned fail_cnt = 0;

  // ack only answers a request that the slave sampled high
  ack_rise_needs_req: assert property (@(posedge CLK) disable iff (!nRST)
    $rose(cfg_ack) |-> $past(cfg_req))
    else begin
      $error("cfg_ack rose while cfg_req was low");
      fail_cnt++;
    end

  // ack drops only after the slave sampled req low
  ack_fall_after_req: assert property (@(posedge CLK) disable iff (!nRST)
    $fell(cfg_ack) |-> $past(!cfg_req))
    else begin
      $error("cfg_ack fell while cfg_req was still high");
      fail_cnt++;
    end

  // no skip while software has skipping switched off
  skip_needs_enable: assert property (@(posedge CLK) disable iff (!nRST)
    skip_valid |-> enable)
    else begin
      $error("skip.valid high with enable low");
      fail_cnt++;
    end

endmodule

bind sparce_top sparce_chk i_chk (
  .CLK        (CLK),
  .nRST       (nRST),
  .cfg_req    (cfg_req),
  .cfg_ack    (cfg_ack),
  .skip_valid (skip.valid),
  .enable     (enable)
);

/* tb/sparce_tb.sv */
/*
 * Testbench for the zero-skipping front end. Loads skip records over the
 * config handshake, drives fetch and writeback, and compares skip and
 * cfg_ack every cycle against a reference model of table, flags and enable.
 */
module sparce_tb;
  import sparce_pkg::*;

  localparam int MAX_CYCLES = 4000;

  logic  CLK;
  logic  nRST;
  addr_t fetch_pc;
  wb_t   wb;
  logic  cfg_req;
  addr_t cfg_addr;
  word_t cfg_data;
  logic  cfg_ack;
  skip_t skip;

  // reference copies of the table, ages, zero flags, enable and handshake
  logic        m_valid [SASA_SETS][SASA_WAYS];
  word_t       m_word  [SASA_SETS][SASA_WAYS];
  int          m_age   [SASA_SETS][SASA_WAYS];
  logic [31:0] m_zero;
  logic        m_enable;
  cfg_state_t  m_state;
  addr_t       m_addr;
  word_t       m_data;

  integer seed;
  int     cycles = 0;
  word_t  r;
  addr_t  pc;
  // pcs that have records for the random phase
  addr_t  rec_pcs[$];

  sparce_top i_dut (.*);

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  task automatic halt_on_error(input string line);
    $display("%s", line);
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped at first error");
  endtask

  // run limit
  always @(posedge CLK) begin
    cycles++;
    if (cycles > MAX_CYCLES) begin
      halt_on_error("timeout: the test sequence did not finish within the cycle limit");
    end
  end

  function automatic void reset_model();
    for (int s = 0; s < SASA_SETS; s++) begin
      for (int w = 0; w < SASA_WAYS; w++) begin
        m_valid[s][w] = 1'b0;
        m_word[s][w]  = 32'h0;
        m_age[s][w]   = SASA_WAYS - 1 - w;
      end
    end
    m_zero   = '1;
    m_enable = 1'b0;
    m_state  = CFG_IDLE;
  endfunction

  // highest matching way in the pc's set or -1 on a miss
  function automatic int hit_way(addr_t a);
    int way;
    way = -1;
    for (int w = 0; w < SASA_WAYS; w++) begin
      if (m_valid[a[3:2]][w] && (m_word[a[3:2]][w][31:18] == a[17:4])) begin
        way = w;
      end
    end
    return way;
  endfunction

  function automatic skip_t model_skip(addr_t a);
    skip_t res;
    int    way;
    word_t rec;
    logic  z1;
    logic  z2;
    logic  cond_ok;
    res = '0;
    way = hit_way(a);
    if (way >= 0) begin
      // record word has rs1 at 15:11, rs2 at 10:6, cond at 5 and count at 4:0
      rec     = m_word[a[3:2]][way];
      z1      = m_zero[rec[15:11]];
      z2      = m_zero[rec[10:6]];
      cond_ok = rec[5] ? (z1 && z2) : (z1 || z2);
      if (m_enable && cond_ok) begin
        res.valid     = 1'b1;
        res.skip_cnt  = rec[4:0];
        // skip the block and the preceding instruction itself
        res.target_pc = a + ((addr_t'(rec[4:0]) + 32'd1) << 2);
      end
    end
    return res;
  endfunction

  // state after the coming rising edge from the inputs now stable
  function automatic void advance_model();
    set_idx_t ws;
    set_idx_t ps;
    int       way;
    int       victim;
    int       hit_age;
    ws  = m_data[17:16];
    ps  = fetch_pc[3:2];
    way = hit_way(fetch_pc);
    if ((m_state == CFG_WRITE) && (m_addr == SASA_TABLE_ADDR)) begin
      victim = 0;
      for (int w = 0; w < SASA_WAYS; w++) begin
        if (m_age[ws][w] == SASA_WAYS - 1) victim = w;
      end
      m_valid[ws][victim] = 1'b1;
      m_word[ws][victim]  = m_data;
      for (int w = 0; w < SASA_WAYS; w++) begin
        m_age[ws][w] = (m_age[ws][w] + 1) % SASA_WAYS;
      end
    end else if (way >= 0) begin
      // move to front with only younger ways stepping back
      hit_age = m_age[ps][way];
      for (int w = 0; w < SASA_WAYS; w++) begin
        if (w == way) m_age[ps][w] = 0;
        else if (m_age[ps][w] < hit_age) m_age[ps][w]++;
      end
    end
    if ((m_state == CFG_WRITE) && (m_addr == SASA_CTRL_ADDR)) m_enable = m_data[0];
    if (wb.en && (wb.rd != 5'd0)) m_zero[wb.rd] = (wb.data == 32'h0);
    case (m_state)
      CFG_IDLE: begin
        if (cfg_req) begin
          m_addr  = cfg_addr;
          m_data  = cfg_data;
          m_state = CFG_WRITE;
        end
      end
      CFG_WRITE: m_state = CFG_ACK;
      default: if (!cfg_req) m_state = CFG_IDLE;
    endcase
  endfunction

  // inputs only change at posedge + 1, so the falling edge sees settled values
  always @(negedge CLK) begin : compare
    skip_t expect_skip;
    if (!nRST) begin
      reset_model();
    end else begin
      expect_skip = model_skip(fetch_pc);
      assert (skip.valid === expect_skip.valid)
        else halt_on_error($sformatf("ERROR at %0t: skip.valid = %0b, expected %0b",
                                     $time, skip.valid, expect_skip.valid));
      assert (skip.skip_cnt === expect_skip.skip_cnt)
        else halt_on_error($sformatf("ERROR at %0t: skip.skip_cnt = %0d, expected %0d",
                                     $time, skip.skip_cnt, expect_skip.skip_cnt));
      assert (skip.target_pc === expect_skip.target_pc)
        else halt_on_error($sformatf("ERROR at %0t: skip.target_pc = %h, expected %h",
                                     $time, skip.target_pc, expect_skip.target_pc));
      // ack high exactly while the slave sits in the ack phase
      assert (cfg_ack === (m_state == CFG_ACK))
        else halt_on_error($sformatf("ERROR at %0t: cfg_ack = %0b, expected %0b",
                                     $time, cfg_ack, (m_state == CFG_ACK)));
      assert (i_dut.i_chk.fail_cnt == 0)
        else halt_on_error("bound checker reported a failed assertion");
      advance_model();
    end
  end

  task automatic next_cycle();
    @(posedge CLK);
    #1;
  endtask

  task automatic hold_fetch(addr_t a, int n);
    fetch_pc = a;
    repeat (n) next_cycle();
  endtask

  // one writeback that the decider sees from the next cycle
  task automatic set_reg(reg_idx_t rd, word_t data);
    wb.en   = 1'b1;
    wb.rd   = rd;
    wb.data = data;
    next_cycle();
    wb.en   = 1'b0;
    next_cycle();
  endtask

  // four-phase transfer where the master holds req for hold extra cycles after ack
  task automatic cfg_write(addr_t addr, word_t data, int hold);
    cfg_addr = addr;
    cfg_data = data;
    cfg_req  = 1'b1;
    next_cycle();
    while (cfg_ack !== 1'b1) next_cycle();
    repeat (hold) next_cycle();
    cfg_req = 1'b0;
    next_cycle();
    while (cfg_ack !== 1'b0) next_cycle();
  endtask

  task automatic write_rec(addr_t a, reg_idx_t rs1, reg_idx_t rs2, sasa_cond_t cond,
                           skip_cnt_t cnt);
    cfg_write(SASA_TABLE_ADDR, {a[17:2], rs1, rs2, cond, cnt}, 0);
    rec_pcs.push_back(a);
  endtask

  initial begin
    seed     = 32'h9b82_1bdb;
    nRST     = 1'b0;
    fetch_pc = 32'h0;
    wb       = '0;
    cfg_req  = 1'b0;
    cfg_addr = 32'h0;
    cfg_data = 32'h0;
    repeat (8) @(posedge CLK);
    #1 nRST = 1'b1;

    // empty table and skipping disabled
    for (int i = 0; i < 16; i++) hold_fetch(32'h100 + i * 4, 1);
    write_rec(32'h100, 5'd0, 5'd5, SASA_COND_OR, 5'd3);
    hold_fetch(32'h100, 4);

    // enable, then OR and AND conditions against changing flags
    cfg_write(SASA_CTRL_ADDR, 32'h1, 0);
    hold_fetch(32'h100, 3);
    write_rec(32'h200, 5'd6, 5'd7, SASA_COND_AND, 5'd2);
    hold_fetch(32'h200, 2);
    set_reg(5'd6, 32'h5);
    set_reg(5'd7, 32'h9);
    set_reg(5'd6, 32'h0);
    set_reg(5'd7, 32'h0);
    write_rec(32'h300, 5'd8, 5'd9, SASA_COND_OR, 5'd1);
    hold_fetch(32'h300, 2);
    set_reg(5'd8, 32'h1);
    set_reg(5'd9, 32'h2);
    set_reg(5'd8, 32'h0);
    // x0 stays zero whatever is written to it
    // x5 goes nonzero so the record at 0x100 hangs on x0 alone
    hold_fetch(32'h100, 1);
    set_reg(5'd5, 32'h3);
    set_reg(5'd0, 32'h7);

    // target pc for several skip counts
    write_rec(32'h408, 5'd0, 5'd0, SASA_COND_OR, 5'd0);
    write_rec(32'h50c, 5'd0, 5'd0, SASA_COND_AND, 5'd17);
    write_rec(32'h60c, 5'd0, 5'd0, SASA_COND_OR, 5'd31);
    hold_fetch(32'h408, 2);
    hold_fetch(32'h50c, 2);
    hold_fetch(32'h60c, 2);

    // five records in set 1 where lookups of the first protect it from eviction
    for (int i = 1; i <= 5; i++) begin
      hold_fetch(32'h1004, 2);
      write_rec(32'h1004 + (i - 1) * 32'h1000, 5'd0, 5'd0, SASA_COND_OR, 5'(i));
      hold_fetch(32'h3004, 1);
    end
    for (int i = 0; i < 5; i++) hold_fetch(32'h1004 + i * 32'h1000, 2);

    // held req stretches ack and unmapped writes change nothing
    for (int i = 0; i < 4; i++) begin
      r = $random(seed);
      cfg_write(32'h0000_2000, r, {29'd0, r[2:0]});
      hold_fetch(32'h200, 2);
      cfg_write(SASA_CTRL_ADDR, 32'h1, {29'd0, r[5:3]});
    end

    // random fetches and writebacks with occasional record and enable writes
    for (int i = 0; i < 400; i++) begin
      r = $random(seed);
      if (r[0]) fetch_pc = rec_pcs[(r >> 8) % rec_pcs.size()];
      else fetch_pc = r & 32'h0003_fffc;
      wb.en   = r[1];
      wb.rd   = r[12:8];
      wb.data = r[13] ? 32'h0 : $random(seed);
      next_cycle();
      if (i % 50 == 49) begin
        wb.en = 1'b0;
        pc    = $random(seed) & 32'h0003_fffc;
        write_rec(pc, r[18:14], r[23:19], sasa_cond_t'(r[24]), r[29:25]);
        cfg_write(SASA_CTRL_ADDR, {31'd0, r[30] | r[31]}, {29'd0, r[4:2]});
      end
    end
    wb.en = 1'b0;
    hold_fetch(32'h0, 4);

    if (i_dut.i_chk.fail_cnt != 0) begin
      halt_on_error("bound checker reported a failed assertion");
    end else begin
      $display("NO ERRORS");
      $finish;
    end
  end

endmodule

/* verilog/sasa_cfg_port.sv */
/*
 * Config slave on a four-phase req/ack handshake.
 * Writes to the table address load a skip record, writes to the control
 * address set the enable bit, anything else is acked and ignored.
 */
module sasa_cfg_port (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  cfg_req,
  input  sparce_pkg::addr_t     cfg_addr,
  input  sparce_pkg::word_t     cfg_data,
  output logic                  cfg_ack,
  output logic                  tbl_wen,
  output sparce_pkg::sasa_rec_t tbl_rec,
  output logic                  enable
);
  import sparce_pkg::*;

  cfg_state_t state;
  cfg_state_t next_state;

  // request captured when accepted
  addr_t addr_q;
  word_t data_q;

  // address decode of the captured request
  logic ctrl_sel;

  always_comb begin
    next_state = state;
    case (state)
      CFG_IDLE:  if (cfg_req) next_state = CFG_WRITE;
      CFG_WRITE: next_state = CFG_ACK;
      // hold ack until the master lets go of req
      CFG_ACK:   if (!cfg_req) next_state = CFG_IDLE;
      default:   next_state = CFG_IDLE;
    endcase
  end

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      state  <= CFG_IDLE;
      enable <= 1'b0;
    end else begin
      state <= next_state;
      if (ctrl_sel) begin
        enable <= data_q[0];
      end
    end
  end

  // latch address and data on acceptance
  always_ff @(posedge CLK) begin
    if ((state == CFG_IDLE) && cfg_req) begin
      addr_q <= cfg_addr;
      data_q <= cfg_data;
    end
  end

  // single write cycle, decoded from the latched address
  assign tbl_wen  = (state == CFG_WRITE) && (addr_q == SASA_TABLE_ADDR);
  assign ctrl_sel = (state == CFG_WRITE) && (addr_q == SASA_CTRL_ADDR);
  // write word has the record layout
  assign tbl_rec  = sasa_rec_t'(data_q);

  assign cfg_ack  = (state == CFG_ACK);

endmodule

/* verilog/sasa_table.sv */
/*
 * Four-way set-associative table of skip records.
 * Combinational lookup by fetch pc, true-LRU ages updated on hits,
 * and fill of the oldest way on each write from the config port.
 */
module sasa_table (
  input  logic                  CLK,
  input  logic                  nRST,
  input  sparce_pkg::addr_t     fetch_pc,
  input  logic                  wen,
  input  sparce_pkg::sasa_rec_t wrec,
  output sparce_pkg::sasa_hit_t lookup
);
  import sparce_pkg::*;

  // control state per way
  logic      valid_q [SASA_SETS][SASA_WAYS];
  lru_age_t  age_q   [SASA_SETS][SASA_WAYS];
  // record payload per way, tag lives in preceding_word[15:2]
  sasa_rec_t rec_q   [SASA_SETS][SASA_WAYS];

  // lookup side
  set_idx_t  pc_set;
  sasa_tag_t pc_tag;
  way_idx_t  hit_way;

  // write side
  set_idx_t  wr_set;
  way_idx_t  wr_way;

  // drop the byte offset, then split word address into set and tag
  assign pc_set = fetch_pc[3:2];
  assign pc_tag = fetch_pc[17:4];

  // the record carries its own word address
  assign wr_set = wrec.preceding_word[1:0];

  // tag compare across the ways of the selected set
  always_comb begin
    lookup  = '0;
    hit_way = '0;
    // ascending scan, so with duplicate tags the highest way wins
    for (int w = 0; w < SASA_WAYS; w++) begin
      if (valid_q[pc_set][w] &&
          (sasa_tag_t'(rec_q[pc_set][w].preceding_word[15:2]) == pc_tag)) begin
        hit_way         = way_idx_t'(w);
        lookup.hit      = 1'b1;
        lookup.rs1      = rec_q[pc_set][w].rs1;
        lookup.rs2      = rec_q[pc_set][w].rs2;
        lookup.cond     = rec_q[pc_set][w].cond;
        lookup.skip_cnt = rec_q[pc_set][w].skip_cnt;
      end
    end
  end

  // victim is the way of age 3 in the write set
  // ages within a set are always a permutation of 0..3, so exactly one matches
  always_comb begin
    wr_way = '0;
    for (int w = 0; w < SASA_WAYS; w++) begin
      if (age_q[wr_set][w] == '1) begin
        wr_way = way_idx_t'(w);
      end
    end
  end

  // valid bits and LRU ages
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      for (int s = 0; s < SASA_SETS; s++) begin
        for (int w = 0; w < SASA_WAYS; w++) begin
          valid_q[s][w] <= 1'b0;
          // way 0 starts oldest, way 3 youngest
          age_q[s][w]   <= lru_age_t'(SASA_WAYS - 1 - w);
        end
      end
    end else if (wen) begin
      // write has priority, any hit update this cycle is lost
      valid_q[wr_set][wr_way] <= 1'b1;
      for (int w = 0; w < SASA_WAYS; w++) begin
        // victim wraps 3 -> 0, everyone else ages by one
        age_q[wr_set][w] <= age_q[wr_set][w] + lru_age_t'(1);
      end
    end else if (lookup.hit) begin
      for (int w = 0; w < SASA_WAYS; w++) begin
        if (way_idx_t'(w) == hit_way) begin
          age_q[pc_set][w] <= '0;
        end else if (age_q[pc_set][w] < age_q[pc_set][hit_way]) begin
          // only ways more recent than the hit way move back
          age_q[pc_set][w] <= age_q[pc_set][w] + lru_age_t'(1);
        end
      end
    end
  end

  // record storage, written into the victim way
  always_ff @(posedge CLK) begin
    if (wen) begin
      rec_q[wr_set][wr_way] <= wrec;
    end
  end

endmodule

/* verilog/skip_decider.sv */
/*
 * Turns a table hit plus the register zero flags into a skip decision.
 * Purely combinational; produces the skip count and redirected fetch pc.
 */
module skip_decider (
  input  sparce_pkg::addr_t               fetch_pc,
  input  sparce_pkg::sasa_hit_t           lookup,
  input  logic [sparce_pkg::NUM_REGS-1:0] zero_flags,
  input  logic                            enable,
  output sparce_pkg::skip_t               skip
);
  import sparce_pkg::*;

  // zero state of the two named source registers
  logic rs1_zero;
  logic rs2_zero;

  // record condition evaluated against the flags
  logic cond_met;

  // block length including the preceding instruction
  addr_t skip_insts;
  // byte distance from fetch_pc to the first instruction after the block
  addr_t jump_bytes;

  assign rs1_zero = zero_flags[lookup.rs1];
  assign rs2_zero = zero_flags[lookup.rs2];

  always_comb begin
    case (lookup.cond)
      SASA_COND_AND: cond_met = rs1_zero && rs2_zero;
      default:       cond_met = rs1_zero || rs2_zero;
    endcase
  end

  // skip_cnt instructions plus the one at fetch_pc, 4 bytes each
  assign skip_insts = addr_t'(lookup.skip_cnt) + addr_t'(1);
  assign jump_bytes = skip_insts << 2;

  always_comb begin
    skip = '0;
    // nothing goes out unless the record hit and software enabled skipping
    if (enable && lookup.hit && cond_met) begin
      skip.valid     = 1'b1;
      skip.skip_cnt  = lookup.skip_cnt;
      skip.target_pc = fetch_pc + jump_bytes;
    end
  end

endmodule

/* verilog/sparce_pkg.sv */
/*
 * Shared definitions for the zero-skipping fetch front end.
 * Holds the table geometry, register map, vector types and the structs
 * passed between the table, tracker, decider and config port.
 */
package sparce_pkg;

  // table geometry, 4 sets of 4 ways
  localparam int SASA_WAYS = 4;
  localparam int SASA_SETS = 4;

  // architectural register file size
  localparam int NUM_REGS = 32;

  // memory-mapped write addresses on the config port
  localparam logic [31:0] SASA_TABLE_ADDR = 32'h0000_1000;
  // bit 0 of the written data is the skip enable
  localparam logic [31:0] SASA_CTRL_ADDR  = 32'h0000_1004;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [4:0]  skip_cnt_t;

  // set index is pc[3:2], tag is pc[17:4]
  typedef logic [1:0]  set_idx_t;
  typedef logic [13:0] sasa_tag_t;

  // 0 = most recently used, 3 = next victim
  typedef logic [1:0]  lru_age_t;
  typedef logic [$clog2(SASA_WAYS)-1:0] way_idx_t;

  typedef enum logic {
    SASA_COND_OR  = 1'b0,  // skip if either source is zero
    SASA_COND_AND = 1'b1   // skip only if both are zero
  } sasa_cond_t;

  typedef enum logic [1:0] {
    CFG_IDLE,
    CFG_WRITE,
    CFG_ACK
  } cfg_state_t;

  // one skip record, laid out exactly like the 32-bit config write word
  typedef struct packed {
    logic [15:0] preceding_word;  // pc[17:2] of the instruction before the block
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    sasa_cond_t  cond;
    skip_cnt_t   skip_cnt;
  } sasa_rec_t;

  typedef struct packed {
    logic       hit;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    sasa_cond_t cond;
    skip_cnt_t  skip_cnt;
  } sasa_hit_t;

  typedef struct packed {
    logic     en;
    reg_idx_t rd;
    word_t    data;
  } wb_t;

  typedef struct packed {
    logic      valid;
    skip_cnt_t skip_cnt;
    addr_t     target_pc;
  } skip_t;

endpackage

/* verilog/sparce_top.sv */
/*
 * Top of the zero-skipping front end.
 * Connects the config port, skip table, zero tracker and skip decider
 * to the core's fetch and writeback ports and to the config bus.
 */
module sparce_top (
  input  logic              CLK,
  input  logic              nRST,
  input  sparce_pkg::addr_t fetch_pc,
  input  sparce_pkg::wb_t   wb,
  input  logic              cfg_req,
  input  sparce_pkg::addr_t cfg_addr,
  input  sparce_pkg::word_t cfg_data,
  output logic              cfg_ack,
  output sparce_pkg::skip_t skip
);
  import sparce_pkg::*;

  // config port to table
  logic      tbl_wen;
  sasa_rec_t tbl_rec;
  // config port to decider
  logic      enable;

  // table lookup result for the current fetch pc
  sasa_hit_t lookup;

  // one bit per register, set while it holds zero
  logic [NUM_REGS-1:0] zero_flags;

  sasa_cfg_port i_cfg_port (
    .CLK      (CLK),
    .nRST     (nRST),
    .cfg_req  (cfg_req),
    .cfg_addr (cfg_addr),
    .cfg_data (cfg_data),
    .cfg_ack  (cfg_ack),
    .tbl_wen  (tbl_wen),
    .tbl_rec  (tbl_rec),
    .enable   (enable)
  );

  sasa_table i_table (
    .CLK      (CLK),
    .nRST     (nRST),
    .fetch_pc (fetch_pc),
    .wen      (tbl_wen),
    .wrec     (tbl_rec),
    .lookup   (lookup)
  );

  zero_reg_tracker i_tracker (
    .CLK        (CLK),
    .nRST       (nRST),
    .wb         (wb),
    .zero_flags (zero_flags)
  );

  skip_decider i_decider (
    .fetch_pc   (fetch_pc),
    .lookup     (lookup),
    .zero_flags (zero_flags),
    .enable     (enable),
    .skip       (skip)
  );

endmodule

/* verilog/zero_reg_tracker.sv */
/*
 * Tracks which architectural registers currently hold zero.
 * Flags follow the writeback port one edge later; x0 is always zero.
 */
module zero_reg_tracker (
  input  logic                              CLK,
  input  logic                              nRST,
  input  sparce_pkg::wb_t                   wb,
  output logic [sparce_pkg::NUM_REGS-1:0]   zero_flags
);
  import sparce_pkg::*;

  // flags for x1..x31, x0 needs no storage
  logic [NUM_REGS-1:1] flags_q;
  logic [NUM_REGS-1:1] flags_d;

  // value being written back is zero
  logic wb_is_zero;

  // writeback targets a real register
  logic wb_live;

  assign wb_is_zero = (wb.data == '0);
  assign wb_live    = wb.en && (wb.rd != '0);

  // next flag values
  always_comb begin
    flags_d = flags_q;
    for (int r = 1; r < NUM_REGS; r++) begin
      // only the destination register changes
      if (wb_live && (wb.rd == reg_idx_t'(r))) begin
        flags_d[r] = wb_is_zero;
      end
    end
  end

  // registers come out of reset holding zero
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      flags_q <= '1;
    end else begin
      flags_q <= flags_d;
    end
  end

  // x0 hardwired zero at bit 0
  assign zero_flags = {flags_q, 1'b1};

endmodule
